/* rtl/board_pkg.sv */
// Board widths, config and activity structs, reset FSM states, seven-segment glyphs
package board_pkg;

  //////////////////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////////////////

  typedef logic [7:0] track_t;   // Floppy track number
  typedef logic [2:0] status_t;  // ROM, RAM, register status
  typedef logic [6:0] seg7_t;    // Active low, bit 0 is seg a
  typedef logic [9:0] sw_t;      // Slide switches
  typedef logic [3:0] key_t;     // Push buttons, low when pressed

  //////////////////////////////////////////////////////////////
  // Grouped signals
  //////////////////////////////////////////////////////////////

  // Configuration straps taken from the switches
  typedef struct packed {
    logic joy_emu_en;       // Keyboard joystick emulation
    logic scandoubler_off;  // 15 kHz video out
    logic exchan;           // Swap audio channels
    logic mix;              // Audio channel mix
    logic boot_sel;         // Boot image select
  } board_cfg_t;

  // Drive activity, pulses in and stretched levels out
  typedef struct packed {
    logic floppy_wr;
    logic floppy_rd;
    logic hd_wr;
    logic hd_rd;
  } activity_t;

  // Core reset sequencer
  typedef enum logic [1:0] {
    RST_HELD  = 2'd0,  // Request active or PLL not locked
    RST_COUNT = 2'd1,  // Request gone, counting ticks
    RST_RUN   = 2'd2   // Core running
  } rst_state_t;

  //////////////////////////////////////////////////////////////
  // Glyphs, segments gfedcba, 0 lights a segment
  //////////////////////////////////////////////////////////////

  localparam seg7_t SEG_HEX [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,  // 0 1 2 3
    7'h19, 7'h12, 7'h02, 7'h78,  // 4 5 6 7
    7'h00, 7'h10, 7'h08, 7'h03,  // 8 9 A b
    7'h46, 7'h21, 7'h06, 7'h0E   // C d E F
  };

  localparam seg7_t SEG_BLANK = 7'h7F;  // All dark
  localparam seg7_t SEG_F     = 7'h0E;  // a e f g
  localparam seg7_t SEG_H     = 7'h09;  // b c e f g

  // Switch positions
  localparam int SW_RESET  = 0;  // Low holds the core in reset
  localparam int SW_MIX    = 5;
  localparam int SW_BOOT   = 6;
  localparam int SW_EXCHAN = 7;
  localparam int SW_15KHZ  = 8;
  localparam int SW_JOYEMU = 9;

  // Key positions
  localparam int KEY_RESET = 0;  // Pressed requests core reset
  localparam int KEY_MB2   = 2;  // Mouse button 2
  localparam int KEY_MB1   = 3;  // Mouse button 1

endpackage

/* rtl/input_sync.sv */
// Multi-stage synchronizer chain for asynchronous board pins
module input_sync #(
  parameter int WIDTH       = 1,
  parameter int SYNC_STAGES = 2
) (
  input  logic             clk_28,
  input  logic             pll_locked,
  input  logic [WIDTH-1:0] din,   // Raw pin levels
  output logic [WIDTH-1:0] dout   // Safe in clk_28 domain
);

  logic [WIDTH-1:0] stage [SYNC_STAGES];

  // Shift chain, stage 0 samples the pins
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[SYNC_STAGES-1];  // Last stage only

endmodule

/* rtl/board_ctrl.sv */
// Switch and key sync, config register, 7 MHz tick and core reset sequencer
module board_ctrl import board_pkg::*; #(
  parameter int SYNC_STAGES    = 2,
  parameter int RST_HOLD_TICKS = 1024
) (
  input  logic       clk_28,
  input  logic       pll_locked,
  input  sw_t        sw,          // Raw switches
  input  key_t       key,         // Raw keys, active low
  output sw_t        sw_sync,     // Registered switch levels
  output board_cfg_t cfg,
  output logic [1:0] mouse_btn,   // Active low, bit 0 is button 1
  output logic       tick_7,      // One clk_28 cycle in four
  output logic       core_rst_n
);

  // Hold counter only needs to reach RST_HOLD_TICKS-1
  localparam int HOLD_W = (RST_HOLD_TICKS > 1) ? $clog2(RST_HOLD_TICKS) : 1;

  sw_t         sw_s;       // Synchronizer outputs
  key_t        key_s;
  logic        rst_req;    // Reset asked by switch or key
  logic [1:0]  clk7_cnt;
  rst_state_t  rst_state;
  logic [HOLD_W-1:0] rst_cnt;

  //////////////////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////////////////

  input_sync #(
    .WIDTH       ($bits(sw_t)),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_sync_sw (
    .clk_28      (clk_28),
    .pll_locked  (pll_locked),
    .din         (sw),
    .dout        (sw_s)
  );

  input_sync #(
    .WIDTH       ($bits(key_t)),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_sync_key (
    .clk_28      (clk_28),
    .pll_locked  (pll_locked),
    .din         (key),
    .dout        (key_s)
  );

  //////////////////////////////////////////////////////////////
  // Configuration register
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      sw_sync   <= '0;
      cfg       <= '0;
      mouse_btn <= 2'b11;  // Released
    end else begin
      sw_sync             <= sw_s;
      cfg.joy_emu_en      <= sw_s[SW_JOYEMU];
      cfg.scandoubler_off <= sw_s[SW_15KHZ];
      cfg.exchan          <= sw_s[SW_EXCHAN];
      cfg.mix             <= sw_s[SW_MIX];
      cfg.boot_sel        <= sw_s[SW_BOOT];
      mouse_btn           <= {key_s[KEY_MB2], key_s[KEY_MB1]};
    end
  end

  //////////////////////////////////////////////////////////////
  // 7 MHz tick
  //////////////////////////////////////////////////////////////

  // Starts at 2 so the first tick comes two cycles out of reset
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      clk7_cnt <= 2'b10;
    end else begin
      clk7_cnt <= clk7_cnt + 2'b01;
    end
  end

  assign tick_7 = (clk7_cnt == 2'b00);  // High on wrap

  //////////////////////////////////////////////////////////////
  // Core reset sequencer
  //////////////////////////////////////////////////////////////

  assign rst_req = !sw_s[SW_RESET] || !key_s[KEY_RESET];

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      rst_state <= RST_HELD;
      rst_cnt   <= '0;
    end else begin
      case (rst_state)
        RST_HELD: begin
          rst_cnt <= '0;
          if (!rst_req) begin
            rst_state <= RST_COUNT;
          end
        end
        RST_COUNT: begin
          if (rst_req) begin
            rst_state <= RST_HELD;  // Restart the hold time
          end else if (tick_7) begin
            if (rst_cnt == HOLD_W'(RST_HOLD_TICKS - 1)) begin
              rst_state <= RST_RUN;
            end else begin
              rst_cnt <= rst_cnt + 1'b1;
            end
          end
        end
        RST_RUN: begin
          if (rst_req) begin
            rst_state <= RST_HELD;
          end
        end
        default: rst_state <= RST_HELD;
      endcase
    end
  end

  assign core_rst_n = (rst_state == RST_RUN);  // Straight from state reg

endmodule

/* rtl/seg7_display.sv */
// Four-digit seven-segment driver for track, status and drive activity
module seg7_display import board_pkg::*; (
  input  logic      clk_28,
  input  logic      pll_locked,
  input  track_t    track,       // From core
  input  status_t   status,      // ROM, RAM, reg bits
  input  activity_t active_s,    // Stretched activity
  input  logic      core_rst_n,
  output seg7_t     hex0,        // Track low nibble
  output seg7_t     hex1,        // Track high nibble
  output seg7_t     hex2,        // Status digit
  output seg7_t     hex3         // Drive type letter
);

  logic  hd_busy;
  logic  fd_busy;
  seg7_t drive_glyph;

  //////////////////////////////////////////////////////////////
  // Drive letter select
  //////////////////////////////////////////////////////////////

  assign hd_busy = active_s.hd_wr || active_s.hd_rd;
  assign fd_busy = active_s.floppy_wr || active_s.floppy_rd;

  // Hard disk wins over floppy
  always_comb begin
    if (!core_rst_n) begin
      drive_glyph = SEG_BLANK;  // Core held, nothing to show
    end else if (hd_busy) begin
      drive_glyph = SEG_H;
    end else if (fd_busy) begin
      drive_glyph = SEG_F;
    end else begin
      drive_glyph = SEG_BLANK;
    end
  end

  //////////////////////////////////////////////////////////////
  // Digit registers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      hex0 <= SEG_BLANK;
      hex1 <= SEG_BLANK;
      hex2 <= SEG_BLANK;
      hex3 <= SEG_BLANK;
    end else begin
      hex0 <= SEG_HEX[track[3:0]];
      hex1 <= SEG_HEX[track[7:4]];
      hex2 <= SEG_HEX[{1'b0, status}];  // 0 to 7 only
      hex3 <= drive_glyph;
    end
  end

endmodule

/* rtl/activity_leds.sv */
// Drive activity pulse stretchers and green and red LED composition
module activity_leds import board_pkg::*; #(
  parameter int STRETCH_TICKS = 4096
) (
  input  logic       clk_28,
  input  logic       pll_locked,
  input  logic       tick_7,      // Count enable
  input  activity_t  activity,    // One-cycle strobes
  input  board_cfg_t cfg,
  input  logic [1:0] mouse_btn,   // Active low
  input  logic       core_rst_n,
  input  sw_t        sw_sync,
  output activity_t  active_s,    // Stretched levels
  output logic [7:0] led_g,
  output sw_t        led_r
);

  localparam int STRETCH_W = $clog2(STRETCH_TICKS + 1);
  localparam int NCH       = $bits(activity_t);

  logic [NCH-1:0]       strobe;    // Flat view of the strobes
  logic [NCH-1:0]       busy;      // Flat view of stretched bits
  logic [STRETCH_W-1:0] cnt [NCH];

  assign strobe = activity;

  //////////////////////////////////////////////////////////////
  // Retriggerable stretchers
  //////////////////////////////////////////////////////////////

  // New strobe reloads, tick counts down to zero
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      for (int i = 0; i < NCH; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NCH; i++) begin
        if (strobe[i]) begin
          cnt[i] <= STRETCH_W'(STRETCH_TICKS);
        end else if (tick_7 && (cnt[i] != '0)) begin
          cnt[i] <= cnt[i] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      busy[i] = (cnt[i] != '0);
    end
  end

  assign active_s = busy;  // Same field order as activity

  //////////////////////////////////////////////////////////////
  // LEDs
  //////////////////////////////////////////////////////////////

  // Activity on the low four greens
  assign led_g[0] = active_s.floppy_wr;
  assign led_g[1] = active_s.floppy_rd;
  assign led_g[2] = active_s.hd_wr;
  assign led_g[3] = active_s.hd_rd;

  // Status on the upper four
  assign led_g[4] = core_rst_n;     // Lit when core runs
  assign led_g[5] = cfg.boot_sel;
  assign led_g[6] = !mouse_btn[0];  // Lit while pressed
  assign led_g[7] = !mouse_btn[1];

  assign led_r = sw_sync;  // Switch echo

endmodule

/* rtl/board_top.sv */
// Board top level joining control block, activity LEDs and digit display
module board_top import board_pkg::*; #(
  parameter int SYNC_STAGES    = 2,
  parameter int RST_HOLD_TICKS = 1024,
  parameter int STRETCH_TICKS  = 4096
) (
  input  logic       clk_28,
  input  logic       pll_locked,   // Also the board reset
  input  sw_t        sw,
  input  key_t       key,
  input  track_t     track,        // Core status inputs
  input  status_t    status,
  input  activity_t  activity,
  output seg7_t      hex0,
  output seg7_t      hex1,
  output seg7_t      hex2,
  output seg7_t      hex3,
  output logic [7:0] led_g,
  output sw_t        led_r,
  output board_cfg_t cfg,          // Core straps
  output logic [1:0] mouse_btn,
  output logic       core_rst_n
);

  sw_t       sw_sync;
  logic      tick_7;
  activity_t active_s;

  //////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////

  board_ctrl #(
    .SYNC_STAGES    (SYNC_STAGES),
    .RST_HOLD_TICKS (RST_HOLD_TICKS)
  ) u_ctrl (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .sw         (sw),
    .key        (key),
    .sw_sync    (sw_sync),
    .cfg        (cfg),
    .mouse_btn  (mouse_btn),
    .tick_7     (tick_7),
    .core_rst_n (core_rst_n)
  );

  //////////////////////////////////////////////////////////////
  // Indicators
  //////////////////////////////////////////////////////////////

  activity_leds #(
    .STRETCH_TICKS (STRETCH_TICKS)
  ) u_leds (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .tick_7     (tick_7),
    .activity   (activity),
    .cfg        (cfg),
    .mouse_btn  (mouse_btn),
    .core_rst_n (core_rst_n),
    .sw_sync    (sw_sync),
    .active_s   (active_s),
    .led_g      (led_g),
    .led_r      (led_r)
  );

  seg7_display u_seg7 (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .track      (track),
    .status     (status),
    .active_s   (active_s),  // Stretched, not raw
    .core_rst_n (core_rst_n),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3)
  );

endmodule

/* dv/board_ref.svh */
// Reference glyphs, expected config and LED values, xorshift generator
`ifndef BOARD_REF_SVH
`define BOARD_REF_SVH

localparam logic [6:0] GLYPH_BLANK = 7'h7F;  // All segments dark
localparam logic [6:0] GLYPH_F     = 7'h0E;  // a e f g lit
localparam logic [6:0] GLYPH_H     = 7'h09;  // b c e f g lit

// Hex digit glyph in gfedcba order where 0 lights a segment
function automatic logic [6:0] seg_glyph(input logic [3:0] d);
  logic [6:0] table_hex [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };
  return table_hex[d];
endfunction

// Straps in field order joy_emu_en, scandoubler_off, exchan, mix, boot_sel
function automatic logic [4:0] expect_cfg(input logic [9:0] sw_in);
  return {sw_in[9], sw_in[8], sw_in[7], sw_in[5], sw_in[6]};
endfunction

// Button 1 on key 3 and button 2 on key 2
function automatic logic [1:0] expect_mouse(input logic [3:0] key_in);
  return {key_in[2], key_in[3]};
endfunction

// Upper greens with the mouse LEDs lit while pressed
function automatic logic [3:0] expect_led_hi(input logic [9:0] sw_in,
                                             input logic [3:0] key_in,
                                             input logic       run);
  return {!key_in[2], !key_in[3], sw_in[6], run};
endfunction

// Drive letter with hard disk first
function automatic logic [6:0] drive_glyph(input logic hd, input logic fd, input logic run);
  if (!run) begin
    return GLYPH_BLANK;
  end
  if (hd) begin
    return GLYPH_H;
  end
  return fd ? GLYPH_F : GLYPH_BLANK;
endfunction

// Strobe pattern for green LED 0 to 3 with floppy_wr as the top bit
function automatic logic [3:0] strobe_for_led(input int led);
  return 4'b1000 >> led;
endfunction

// 32-bit xorshift with shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

`endif

/* dv/board_tb.sv */
// Board glue testbench with clock, reset, stimulus, comparison and watchdog
module board_tb import board_pkg::*; ();

  localparam int HOLD_TICKS    = 8;
  localparam int STRETCH_TICKS = 16;
  localparam int CFG_ROUNDS    = 16;
  localparam int DIGIT_ROUNDS  = 16;
  localparam int TEST_CYCLES   = 8 + 4*CFG_ROUNDS + 2*DIGIT_ROUNDS + 3*(4*HOLD_TICKS + 8)
                                 + 6*(4*STRETCH_TICKS + 16);
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 300;  // Margin for wait loops

  logic       clk_28 = 1'b0;
  logic       pll_locked;
  sw_t        sw;
  key_t       key;
  track_t     track;
  status_t    status;
  activity_t  activity;
  seg7_t      hex0, hex1, hex2, hex3;
  logic [7:0] led_g;
  sw_t        led_r;
  board_cfg_t cfg;
  logic [1:0] mouse_btn;
  logic       core_rst_n;
  logic [8:0] watched;                // Core reset on top of the greens
  logic [31:0] rng = 32'he0e9_d091;
  logic       was_run = 1'b0;         // core_rst_n one cycle back
  int         mismatch_cnt = 0;
  int         fail_cnt = 0;

  `include "board_ref.svh"

  always #10 clk_28 = ~clk_28;  // 20 unit period

  board_top #(
    .RST_HOLD_TICKS (HOLD_TICKS),
    .STRETCH_TICKS  (STRETCH_TICKS)
  ) uut (.*);

  assign watched = {core_rst_n, led_g};

  ////////////////////////////////////////////////////////////
  // Check helpers
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      mismatch_cnt++;
      $display("mismatch %s: expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic check_window(input string name, input int n, input int lo, input int hi);
    assert (n >= lo && n <= hi) else begin
      fail_cnt++;
      $display("%s took %0d cycles, allowed %0d to %0d", name, n, lo, hi);
    end
  endtask

  // Counts edges until the watched bit reaches level or passes max
  task automatic wait_bit(input int sel, input logic level, input int max_cycles,
                          output int cycles);
    cycles = 0;
    while (watched[sel] !== level && cycles <= max_cycles) begin
      @(posedge clk_28);
      @(negedge clk_28);
      cycles++;
    end
  endtask

  task automatic pulse_activity(input logic [3:0] pattern);
    @(posedge clk_28);
    activity <= pattern;
    @(posedge clk_28);
    activity <= '0;   // One cycle only
    @(negedge clk_28);
  endtask

  // Strobe one channel and follow its green LED and the drive digit to expiry
  task automatic stretch_channel(input int ch);
    int n;
    pulse_activity(strobe_for_led(ch));
    wait_bit(ch, 1'b1, 3, n);
    check_window("stretch rise", n + 1, 1, 3);
    repeat (4*STRETCH_TICKS - 4) @(posedge clk_28);
    @(negedge clk_28);
    check_eq("stretch hold", 1, led_g[ch]);
    check_eq("drive digit", drive_glyph(ch >= 2, ch < 2, 1'b1), hex3);
    wait_bit(ch, 1'b0, 11, n);      // Bound of 4*16+8 from the strobe
    check_window("stretch expiry", n, 0, 11);
    @(posedge clk_28);
    @(negedge clk_28);
    check_eq("drive digit idle", GLYPH_BLANK, hex3);
  endtask

  // Reset LED and dark digit while the core is held, every cycle
  always @(negedge clk_28) begin
    if (pll_locked) begin
      check_eq("led_g[4]", core_rst_n, led_g[4]);
      if (!was_run) begin
        check_eq("held hex3", GLYPH_BLANK, hex3);
      end
    end
    was_run = core_rst_n;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int n;
    pll_locked = 1'b0;
    sw         = '0;
    key        = 4'b1110;  // Reset key pressed and mouse buttons up
    track      = '0;
    status     = '0;
    activity   = '0;
    repeat (8) @(posedge clk_28);
    pll_locked <= 1'b1;
    @(negedge clk_28);
    check_eq("reset core_rst_n", 0, core_rst_n);
    check_eq("reset hex3", GLYPH_BLANK, hex3);
    check_eq("reset greens", 0, led_g[3:0]);

    for (int i = 0; i < CFG_ROUNDS; i++) begin
      rng = xorshift32(rng);
      @(posedge clk_28);
      sw  <= rng[9:0];
      key <= {rng[13:11], 1'b0};  // Core stays held
      repeat (3) @(posedge clk_28);
      @(negedge clk_28);
      check_eq("cfg", expect_cfg(sw), cfg);
      check_eq("mouse_btn", expect_mouse(key), mouse_btn);
      check_eq("led_r", sw, led_r);
      check_eq("led_g[7:4]", expect_led_hi(sw, key, 1'b0), led_g[7:4]);
    end

    for (int i = 0; i < DIGIT_ROUNDS; i++) begin
      rng = xorshift32(rng);
      @(posedge clk_28);
      track  <= rng[7:0];
      status <= rng[10:8];
      @(posedge clk_28);
      @(negedge clk_28);
      check_eq("hex0", seg_glyph(track[3:0]), hex0);
      check_eq("hex1", seg_glyph(track[7:4]), hex1);
      check_eq("hex2", seg_glyph({1'b0, status}), hex2);
    end

    // Release and press again, then release for the activity tests
    for (int i = 0; i < 3; i++) begin
      @(posedge clk_28);
      sw[0]  <= 1'b1;
      key[0] <= (i == 1) ? 1'b0 : 1'b1;
      @(negedge clk_28);
      if (i == 1) begin
        wait_bit(8, 1'b0, 6, n);
        check_window("core reset fall", n, 0, 6);
      end else begin
        wait_bit(8, 1'b1, 4*HOLD_TICKS + 8, n);
        check_window("core reset rise", n, 4*HOLD_TICKS, 4*HOLD_TICKS + 8);
      end
    end

    for (int ch = 0; ch < 4; ch++) begin
      stretch_channel(ch);
    end

    // Retrigger halfway keeps floppy_rd lit past one stretch
    pulse_activity(strobe_for_led(1));
    repeat (4*STRETCH_TICKS - 24) @(posedge clk_28);
    pulse_activity(strobe_for_led(1));
    repeat (4*STRETCH_TICKS - 24) @(posedge clk_28);
    @(negedge clk_28);
    check_eq("retrigger hold", 1, led_g[1]);
    wait_bit(1, 1'b0, 4*STRETCH_TICKS, n);
    check_window("retrigger expiry", n, 0, 4*STRETCH_TICKS);

    // Floppy alone and then hard disk over floppy
    pulse_activity(strobe_for_led(0));
    @(posedge clk_28);
    @(negedge clk_28);
    check_eq("floppy digit", drive_glyph(1'b0, 1'b1, 1'b1), hex3);
    pulse_activity(strobe_for_led(1) | strobe_for_led(3));
    @(posedge clk_28);
    @(negedge clk_28);
    check_eq("hd over floppy digit", drive_glyph(1'b1, 1'b1, 1'b1), hex3);
    wait_bit(1, 1'b0, 4*STRETCH_TICKS + 8, n);
    check_window("mixed expiry", n, 0, 4*STRETCH_TICKS + 8);
    @(posedge clk_28);
    @(negedge clk_28);
    check_eq("all expired greens", 0, led_g[3:0]);
    check_eq("all expired digit", GLYPH_BLANK, hex3);

    // Digit stays dark for a strobe while the core is held
    @(posedge clk_28);
    key[0] <= 1'b0;
    pulse_activity(strobe_for_led(2));
    wait_bit(8, 1'b0, 6, n);
    check_window("second core reset fall", n, 0, 6);
    repeat (2) @(posedge clk_28);
    @(negedge clk_28);
    check_eq("held drive digit", drive_glyph(1'b1, 1'b0, 1'b0), hex3);

    $display("Checks done: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_28);
    $display("Watchdog expired after %0d cycles with %0d mismatches, %0d other failures",
             TIMEOUT_CYCLES, mismatch_cnt, fail_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+dv
rtl/board_pkg.sv
rtl/input_sync.sv
rtl/board_ctrl.sv
rtl/seg7_display.sv
rtl/activity_leds.sv
rtl/board_top.sv
dv/board_tb.sv

/* Bender.yml */
package:
  name: board_glue

sources:
  - rtl/board_pkg.sv
  - rtl/input_sync.sv
  - rtl/board_ctrl.sv
  - rtl/seg7_display.sv
  - rtl/activity_leds.sv
  - rtl/board_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/board_tb.sv
